// ==== common/eth_dma_pkg.sv ====
`default_nettype none

package eth_dma_pkg;

   // Bus and memory widths
   localparam int BD_ADDR_W  = 8;
   localparam int BUF_ADDR_W = 11;
   localparam int AXI_ADDR_W = 32;
   localparam int AXI_DATA_W = 32;
   localparam int AXI_LEN_W  = 8;

   // Frame layout in the transmit buffer
   localparam int PREAMBLE_LEN  = 7;
   localparam int PRE_FRAME_LEN = PREAMBLE_LEN + 1;
   localparam int MAX_BURST_LEN = 16;

   // Descriptor control word fields
   localparam int BD_LEN_LSB   = 16;
   localparam int BD_READY_BIT = 15;
   localparam int BD_IRQ_BIT   = 14;
   localparam int BD_WRAP_BIT  = 13;
   localparam int BD_CRC_BIT   = 11;

   typedef logic [BD_ADDR_W-1:0]  bd_addr_t;
   typedef logic [BD_ADDR_W-2:0]  bd_num_t;
   typedef logic [BUF_ADDR_W-1:0] buf_addr_t;
   typedef logic [7:0]            byte_t;
   typedef logic [AXI_DATA_W-1:0] word_t;
   typedef logic [BUF_ADDR_W-1:0] frame_len_t;
   typedef logic [AXI_LEN_W-1:0]  axi_len_t;

   localparam byte_t PREAMBLE_BYTE = 8'h55;
   localparam byte_t SFD_BYTE      = 8'hD5;

   // One frame to copy, built from a descriptor
   typedef struct packed {
      word_t      ptr;
      frame_len_t nbytes;
      logic       crc_en;
      logic       irq_en;
      logic       wrap;
   } tx_job_t;

   typedef struct packed {
      logic [AXI_ADDR_W-1:0] addr;
      axi_len_t              len;
   } axi_ar_t;

   typedef struct packed {
      logic      wen;
      buf_addr_t addr;
      byte_t     data;
   } buf_wr_t;

   // Length here counts the preamble and SFD once it leaves the DMA
   typedef struct packed {
      frame_len_t nbytes;
      logic       crc_en;
   } frame_info_t;

   typedef enum logic [2:0] {
      BD_RD_CTRL,
      BD_CHK_CTRL,
      BD_RD_PTR,
      BD_LATCH_PTR,
      BD_RUN,
      BD_WRITEBACK
   } bd_state_e;

   typedef enum logic [1:0] {
      RD_IDLE,
      RD_ADDR,
      RD_DATA,
      RD_DONE
   } rd_state_e;

   typedef enum logic [1:0] {
      FW_PREFILL,
      FW_IDLE,
      FW_SEND,
      FW_RELEASE
   } fw_state_e;

endpackage

`default_nettype wire

// ==== logic/frame_writer.sv ====
`timescale 1ns/1ns
`default_nettype none

module frame_writer
   import eth_dma_pkg::*;
(
   input  logic        clk_i,
   input  logic        arst_i,
   input  buf_wr_t     byte_wr_i,
   input  frame_info_t frame_i,
   input  logic        frame_req_i,
   output logic        frame_ack_o,
   output logic        prefill_done_o,
   output buf_wr_t     buf_wr_o,
   output frame_info_t frame_info_o,
   output logic        send_req_o,
   input  logic        send_ack_i
);

   fw_state_e state_q;
   buf_addr_t pre_cnt_q;
   buf_wr_t   pre_wr;
   buf_wr_t   wr_next;
   buf_wr_t   wr_q;
   logic      start;

   // Preamble bytes, then SFD in the last slot
   assign pre_wr.wen  = 1'b1;
   assign pre_wr.addr = pre_cnt_q;
   assign pre_wr.data = (pre_cnt_q == buf_addr_t'(PREAMBLE_LEN)) ? SFD_BYTE : PREAMBLE_BYTE;

   assign wr_next = (state_q == FW_PREFILL) ? pre_wr : byte_wr_i;

   always_ff @(posedge clk_i) begin
      if (arst_i) begin
         wr_q.wen <= 1'b0;
      end else begin
         wr_q <= wr_next;
      end
   end

   assign buf_wr_o = wr_q;

   assign start = (state_q == FW_IDLE) && frame_req_i && !frame_ack_o && !send_ack_i;

   always_ff @(posedge clk_i) begin
      if (arst_i) begin
         state_q     <= FW_PREFILL;
         pre_cnt_q   <= '0;
         frame_ack_o <= 1'b0;
      end else begin
         case (state_q)
            FW_PREFILL: begin
               pre_cnt_q <= pre_cnt_q + 1'b1;
               if (pre_cnt_q == buf_addr_t'(PRE_FRAME_LEN - 1)) begin
                  state_q <= FW_IDLE;
               end
            end
            FW_IDLE: begin
               if (frame_ack_o && !frame_req_i) begin
                  frame_ack_o <= 1'b0;
               end
               if (start) begin
                  state_q <= FW_SEND;
               end
            end
            FW_SEND: begin
               if (send_ack_i) begin
                  state_q <= FW_RELEASE;
               end
            end
            FW_RELEASE: begin
               // Transmitter done once ack is back low
               if (!send_ack_i) begin
                  frame_ack_o <= 1'b1;
                  state_q     <= FW_IDLE;
               end
            end
            default: begin
               state_q <= FW_IDLE;
            end
         endcase
      end
   end

   always_ff @(posedge clk_i) begin
      if (start) begin
         frame_info_o.nbytes <= frame_i.nbytes + frame_len_t'(PRE_FRAME_LEN);
         frame_info_o.crc_en <= frame_i.crc_en;
      end
   end

   assign prefill_done_o = (state_q != FW_PREFILL);
   assign send_req_o     = (state_q == FW_SEND);

   // Transmitter must have released its previous ack
   assert property (@(posedge clk_i) disable iff (arst_i) $rose(send_req_o) |-> !send_ack_i);

endmodule

`default_nettype wire

// ==== tx_dma/bd_fetch.sv ====
`timescale 1ns/1ns
`default_nettype none

module bd_fetch
   import eth_dma_pkg::*;
(
   input  logic     clk_i,
   input  logic     arst_i,
   input  logic     tx_en_i,
   input  bd_num_t  tx_bd_num_i,
   input  word_t    bd_rdata_i,
   output bd_addr_t bd_addr_o,
   output logic     bd_wen_o,
   output word_t    bd_wdata_o,
   output tx_job_t  job_o,
   output logic     job_req_o,
   input  logic     job_ack_i,
   output logic     tx_irq_o
);

   bd_state_e state_q;
   bd_num_t   bd_num_q;
   bd_num_t   bd_num_inc;
   bd_num_t   bd_num_next;
   word_t     ctrl_q;
   word_t     ptr_q;
   logic      ctrl_ok;

   // Ready bit checked on the word coming back from memory
   assign ctrl_ok = bd_rdata_i[BD_READY_BIT] & tx_en_i;

   assign bd_num_inc = bd_num_q + 1'b1;

   // Wrap bit or end of ring sends us back to descriptor 0
   assign bd_num_next = (ctrl_q[BD_WRAP_BIT] || (bd_num_inc >= tx_bd_num_i)) ? '0 : bd_num_inc;

   always_ff @(posedge clk_i) begin
      if (arst_i) begin
         state_q  <= BD_RD_CTRL;
         bd_num_q <= '0;
      end else begin
         case (state_q)
            BD_RD_CTRL: begin
               state_q <= BD_CHK_CTRL;
            end
            BD_CHK_CTRL: begin
               // Poll again if not ready
               if (ctrl_ok) begin
                  state_q <= BD_RD_PTR;
               end else begin
                  state_q <= BD_RD_CTRL;
               end
            end
            BD_RD_PTR: begin
               state_q <= BD_LATCH_PTR;
            end
            BD_LATCH_PTR: begin
               state_q <= BD_RUN;
            end
            BD_RUN: begin
               if (job_ack_i) begin
                  state_q <= BD_WRITEBACK;
               end
            end
            BD_WRITEBACK: begin
               // Write happens once the ack has dropped
               if (!job_ack_i) begin
                  state_q  <= BD_RD_CTRL;
                  bd_num_q <= bd_num_next;
               end
            end
            default: begin
               state_q <= BD_RD_CTRL;
            end
         endcase
      end
   end

   always_ff @(posedge clk_i) begin
      if (state_q == BD_CHK_CTRL) begin
         ctrl_q <= bd_rdata_i;
      end
      if (state_q == BD_LATCH_PTR) begin
         ptr_q <= bd_rdata_i;
      end
   end

   // Control word at 2n, pointer at 2n+1
   assign bd_addr_o = {bd_num_q, (state_q == BD_RD_PTR)};
   assign bd_wen_o  = (state_q == BD_WRITEBACK) && !job_ack_i;
   assign tx_irq_o  = bd_wen_o & ctrl_q[BD_IRQ_BIT];

   always_comb begin
      bd_wdata_o               = ctrl_q;
      bd_wdata_o[BD_READY_BIT] = 1'b0;
   end

   assign job_req_o     = (state_q == BD_RUN);
   assign job_o.ptr     = ptr_q;
   assign job_o.nbytes  = ctrl_q[BD_LEN_LSB +: BUF_ADDR_W];
   assign job_o.crc_en  = ctrl_q[BD_CRC_BIT];
   assign job_o.irq_en  = ctrl_q[BD_IRQ_BIT];
   assign job_o.wrap    = ctrl_q[BD_WRAP_BIT];

   // Job ack only answers a job that is still offered
   assert property (@(posedge clk_i) disable iff (arst_i) $rose(job_ack_i) |-> job_req_o);

endmodule

`default_nettype wire

// ==== tx_dma/burst_reader.sv ====
`timescale 1ns/1ns
`default_nettype none

module burst_reader
   import eth_dma_pkg::*;
(
   input  logic        clk_i,
   input  logic        arst_i,
   input  tx_job_t     job_i,
   input  logic        job_req_i,
   output logic        job_ack_o,
   input  logic        prefill_done_i,
   output axi_ar_t     axi_ar_o,
   output logic        axi_arvalid_o,
   input  logic        axi_arready_i,
   input  word_t       axi_rdata_i,
   input  logic        axi_rvalid_i,
   input  logic        axi_rlast_i,
   output logic        axi_rready_o,
   output buf_wr_t     byte_wr_o,
   output frame_info_t frame_o,
   input  logic        frame_ack_i,
   output logic        frame_req_o
);

   rd_state_e  state_q;
   frame_len_t count_q;
   frame_len_t remain;
   word_t      byte_addr;
   logic       beat;
   logic       start;

   assign remain    = job_i.nbytes - count_q;
   assign byte_addr = job_i.ptr + word_t'(count_q);
   assign beat      = axi_rvalid_i & axi_rready_o;

   // New job only after prefill and a finished frame handshake
   assign start = job_req_i && prefill_done_i && !job_ack_o && !frame_ack_i;

   always_ff @(posedge clk_i) begin
      if (arst_i) begin
         state_q   <= RD_IDLE;
         count_q   <= '0;
         job_ack_o <= 1'b0;
      end else begin
         case (state_q)
            RD_IDLE: begin
               if (job_ack_o && !job_req_i) begin
                  job_ack_o <= 1'b0;
               end
               if (start) begin
                  count_q <= '0;
                  state_q <= RD_ADDR;
               end
            end
            RD_ADDR: begin
               if (remain == '0) begin
                  state_q <= RD_DONE;
               end else if (axi_arready_i) begin
                  state_q <= RD_DATA;
               end
            end
            RD_DATA: begin
               if (beat) begin
                  count_q <= count_q + 1'b1;
                  if (axi_rlast_i) begin
                     state_q <= RD_ADDR;
                  end
               end
            end
            RD_DONE: begin
               // Transmitter has the frame, release the descriptor
               if (frame_ack_i) begin
                  job_ack_o <= 1'b1;
                  state_q   <= RD_IDLE;
               end
            end
            default: begin
               state_q <= RD_IDLE;
            end
         endcase
      end
   end

   // Burst is min(16, bytes left) beats
   assign axi_ar_o.addr = byte_addr;
   assign axi_ar_o.len  = (remain >= frame_len_t'(MAX_BURST_LEN)) ?
                          axi_len_t'(MAX_BURST_LEN - 1) :
                          axi_len_t'(remain - 1'b1);

   assign axi_arvalid_o = (state_q == RD_ADDR) && (remain != '0);
   assign axi_rready_o  = (state_q == RD_DATA);

   // One byte per beat, lane from the low address bits
   assign byte_wr_o.wen  = beat;
   assign byte_wr_o.addr = buf_addr_t'(PRE_FRAME_LEN) + buf_addr_t'(count_q);
   assign byte_wr_o.data = axi_rdata_i[{byte_addr[1:0], 3'b000} +: 8];

   assign frame_req_o    = (state_q == RD_DONE);
   assign frame_o.nbytes = job_i.nbytes;
   assign frame_o.crc_en = job_i.crc_en;

   // Address held steady until the slave takes it
   assert property (@(posedge clk_i) disable iff (arst_i)
      axi_arvalid_o && !axi_arready_i |=> axi_arvalid_o && $stable(axi_ar_o));

endmodule

`default_nettype wire

// ==== tx_dma/eth_tx_dma.sv ====
`timescale 1ns/1ns
`default_nettype none

module eth_tx_dma
   import eth_dma_pkg::*;
(
   input  logic        clk_i,
   input  logic        arst_i,
   input  logic        tx_en_i,
   input  bd_num_t     tx_bd_num_i,
   // Descriptor memory
   output bd_addr_t    bd_addr_o,
   output logic        bd_wen_o,
   output word_t       bd_wdata_o,
   input  word_t       bd_rdata_i,
   // AXI read
   output axi_ar_t     axi_ar_o,
   output logic        axi_arvalid_o,
   input  logic        axi_arready_i,
   input  word_t       axi_rdata_i,
   input  logic        axi_rvalid_i,
   input  logic        axi_rlast_i,
   output logic        axi_rready_o,
   // Frame buffer and transmitter
   output buf_wr_t     buf_wr_o,
   output frame_info_t frame_info_o,
   output logic        send_req_o,
   input  logic        send_ack_i,
   output logic        tx_irq_o
);

   tx_job_t     job;
   logic        job_req;
   logic        job_ack;
   logic        prefill_done;
   buf_wr_t     byte_wr;
   frame_info_t frame;
   logic        frame_req;
   logic        frame_ack;

   bd_fetch i_bd_fetch (
      .clk_i       (clk_i),
      .arst_i      (arst_i),
      .tx_en_i     (tx_en_i),
      .tx_bd_num_i (tx_bd_num_i),
      .bd_rdata_i  (bd_rdata_i),
      .bd_addr_o   (bd_addr_o),
      .bd_wen_o    (bd_wen_o),
      .bd_wdata_o  (bd_wdata_o),
      .job_o       (job),
      .job_req_o   (job_req),
      .job_ack_i   (job_ack),
      .tx_irq_o    (tx_irq_o)
   );

   burst_reader i_burst_reader (
      .clk_i          (clk_i),
      .arst_i         (arst_i),
      .job_i          (job),
      .job_req_i      (job_req),
      .job_ack_o      (job_ack),
      .prefill_done_i (prefill_done),
      .axi_ar_o       (axi_ar_o),
      .axi_arvalid_o  (axi_arvalid_o),
      .axi_arready_i  (axi_arready_i),
      .axi_rdata_i    (axi_rdata_i),
      .axi_rvalid_i   (axi_rvalid_i),
      .axi_rlast_i    (axi_rlast_i),
      .axi_rready_o   (axi_rready_o),
      .byte_wr_o      (byte_wr),
      .frame_o        (frame),
      .frame_ack_i    (frame_ack),
      .frame_req_o    (frame_req)
   );

   frame_writer i_frame_writer (
      .clk_i          (clk_i),
      .arst_i         (arst_i),
      .byte_wr_i      (byte_wr),
      .frame_i        (frame),
      .frame_req_i    (frame_req),
      .frame_ack_o    (frame_ack),
      .prefill_done_o (prefill_done),
      .buf_wr_o       (buf_wr_o),
      .frame_info_o   (frame_info_o),
      .send_req_o     (send_req_o),
      .send_ack_i     (send_ack_i)
   );

endmodule

`default_nettype wire

// ==== dv/tb_eth_tx_dma.sv ====
`timescale 1ns/1ns
`default_nettype none

module tb_eth_tx_dma
   import eth_dma_pkg::*;
();

   localparam int NUM_FRAMES      = 6;
   localparam int CLK_PERIOD      = 40;
   localparam int WATCHDOG_CYCLES = NUM_FRAMES * 400 + 100;
   localparam int STALL_CYCLES    = 20;
   localparam int TXEN_OFF_CYCLES = 30;

   logic        clk_i;
   logic        arst_i;
   logic        tx_en_i;
   bd_num_t     tx_bd_num_i;
   bd_addr_t    bd_addr_o;
   logic        bd_wen_o;
   word_t       bd_wdata_o;
   word_t       bd_rdata_i;
   axi_ar_t     axi_ar_o;
   logic        axi_arvalid_o;
   logic        axi_arready_i;
   word_t       axi_rdata_i;
   logic        axi_rvalid_i;
   logic        axi_rlast_i;
   logic        axi_rready_o;
   buf_wr_t     buf_wr_o;
   frame_info_t frame_info_o;
   logic        send_req_o;
   logic        send_ack_i;
   logic        tx_irq_o;

   word_t    bd_mem [0:255];
   word_t    stim [0:3*NUM_FRAMES-1];
   integer   seed;
   int       errors;
   int       checks;
   int       frames_done;
   int       frame_k;
   int       cur_idx;
   int       cur_len;
   int       copied;
   int       wr_cnt;
   int       pre_cnt;
   int       stall_cnt;
   int       ack_wait;
   int       beats_left;
   word_t    cur_ctrl;
   word_t    cur_ptr;
   word_t    burst_addr;
   logic     prev_req;
   logic     prog_pending;
   logic     ready_pending;
   bd_addr_t addr_s;
   logic     wen_s;
   word_t    wdata_s;
   logic     arready_n;
   logic     rvalid_n;
   logic     rlast_n;
   logic     ack_n;
   word_t    rdata_n;

   eth_tx_dma i_eth_tx_dma (.*);

   always #(CLK_PERIOD / 2) clk_i = ~clk_i;

   task automatic check(input string name, input logic [31:0] exp, input logic [31:0] act);
      checks++;
      if (exp !== act) begin
         errors++;
         $display("Error at %0t ns: %s expected 0x%0h, got 0x%0h", $time, name, exp, act);
      end
   endtask

   // Current frame comes from stim line k and is served by descriptor idx
   task automatic load_frame(input int k, input int idx);
      logic [4:0] sidx;
      sidx      = 5'(3 * k);
      cur_ctrl  = stim[sidx];
      cur_ptr   = stim[sidx + 5'd1];
      cur_len   = int'(cur_ctrl[31:16]);
      cur_idx   = idx;
      copied    = 0;
      wr_cnt    = 0;
      stall_cnt = cur_ctrl[BD_READY_BIT] ? 0 : STALL_CYCLES;
   endtask

   task automatic program_desc();
      bd_mem[bd_addr_t'(2 * cur_idx)]     = cur_ctrl;
      bd_mem[bd_addr_t'(2 * cur_idx + 1)] = cur_ptr;
   endtask

   // Mid-cycle sampling of the DUT outputs
   task automatic sample_outputs();
      word_t      a;
      int         remain;
      int         exp_len;
      logic [4:0] sidx;
      addr_s  = bd_addr_o;
      wen_s   = bd_wen_o;
      wdata_s = bd_wdata_o;
      if (!tx_en_i || stall_cnt > 0) begin
         check("axi_arvalid_o", 32'(0), 32'(axi_arvalid_o));
      end
      if (stall_cnt > 0) begin
         stall_cnt--;
         if (stall_cnt == 0) begin
            ready_pending = 1'b1;
         end
      end
      if (buf_wr_o.wen) begin
         if (pre_cnt < PRE_FRAME_LEN) begin
            check("buf_wr_o.addr", 32'(pre_cnt), 32'(buf_wr_o.addr));
            check("buf_wr_o.data", 32'(pre_cnt == 7 ? 8'hD5 : 8'h55), 32'(buf_wr_o.data));
            pre_cnt++;
         end else begin
            a = cur_ptr + word_t'(wr_cnt);
            check("buf_wr_o.addr", 32'(8 + wr_cnt), 32'(buf_wr_o.addr));
            check("buf_wr_o.data", 32'(a[7:0] ^ 8'hA5), 32'(buf_wr_o.data));
            wr_cnt++;
         end
      end
      // Data is only taken while a burst is outstanding
      check("axi_rready_o", 32'(beats_left > 0), 32'(axi_rready_o));
      if (axi_rvalid_i && axi_rready_o) begin
         burst_addr = burst_addr + 32'd1;
         beats_left--;
         copied++;
      end
      if (axi_arvalid_o && axi_arready_i) begin
         remain  = cur_len - copied;
         exp_len = (remain > 16 ? 16 : remain) - 1;
         check("axi_ar_o.addr", cur_ptr + word_t'(copied), axi_ar_o.addr);
         check("axi_ar_o.len", 32'(exp_len), 32'(axi_ar_o.len));
         burst_addr = axi_ar_o.addr;
         beats_left = int'(axi_ar_o.len) + 1;
      end
      // Frame offered to the transmitter
      if (send_req_o && !prev_req) begin
         check("send_ack_i", 32'(0), 32'(send_ack_i));
         check("frame_info_o.nbytes", 32'(cur_len + 8), 32'(frame_info_o.nbytes));
         check("frame_info_o.crc_en", 32'(cur_ctrl[BD_CRC_BIT]), 32'(frame_info_o.crc_en));
         check("frame bytes written", 32'(cur_len), 32'(wr_cnt));
      end
      if (!send_req_o && prev_req) begin
         check("send_ack_i", 32'(1), 32'(send_ack_i));
      end
      if (send_req_o != send_ack_i) begin
         if (ack_wait == 0) begin
            ack_n    = send_req_o;
            ack_wait = $random(seed) & 7;
         end else begin
            ack_wait--;
         end
      end
      prev_req = send_req_o;
      if (!bd_wen_o) begin
         check("tx_irq_o", 32'(0), 32'(tx_irq_o));
      end else begin
         check("bd_addr_o", 32'(2 * cur_idx), 32'(bd_addr_o));
         check("bd_wdata_o", cur_ctrl & ~32'h0000_8000, bd_wdata_o);
         check("tx_irq_o", 32'(cur_ctrl[BD_IRQ_BIT]), 32'(tx_irq_o));
         check("bytes copied", 32'(cur_len), 32'(copied));
         frames_done++;
         if (frames_done < NUM_FRAMES) begin
            sidx = 5'(3 * frame_k + 2);
            frame_k++;
            load_frame(frame_k, int'(stim[sidx]));
            prog_pending = 1'b1;
         end
      end
      // Memory slave with random stalls
      arready_n = ($random(seed) & 3) != 0;
      if (beats_left > 0) begin
         rvalid_n = ($random(seed) & 3) != 0;
         rdata_n  = {24'h0, burst_addr[7:0] ^ 8'hA5} << {burst_addr[1:0], 3'b000};
         rlast_n  = (beats_left == 1);
      end else begin
         rvalid_n = 1'b0;
         rdata_n  = '0;
         rlast_n  = 1'b0;
      end
   endtask

   task automatic drive_inputs();
      bd_rdata_i = bd_mem[addr_s];
      if (wen_s) begin
         bd_mem[addr_s] = wdata_s;
      end
      if (prog_pending) begin
         program_desc();
         prog_pending = 1'b0;
      end
      if (ready_pending) begin
         bd_mem[bd_addr_t'(2 * cur_idx)][BD_READY_BIT] = 1'b1;
         ready_pending = 1'b0;
      end
      axi_arready_i = arready_n;
      axi_rvalid_i  = rvalid_n;
      axi_rdata_i   = rdata_n;
      axi_rlast_i   = rlast_n;
      send_ack_i    = ack_n;
   endtask

   always begin
      @(negedge clk_i);
      if (!arst_i) begin
         sample_outputs();
      end
      @(posedge clk_i);
      #2;
      drive_inputs();
   end

   initial begin
      clk_i         = 1'b0;
      arst_i        = 1'b1;
      tx_en_i       = 1'b0;
      tx_bd_num_i   = bd_num_t'(3);
      bd_rdata_i    = '0;
      axi_arready_i = 1'b0;
      axi_rdata_i   = '0;
      axi_rvalid_i  = 1'b0;
      axi_rlast_i   = 1'b0;
      send_ack_i    = 1'b0;
      seed          = 32'h6cc2d1fa;
      errors        = 0;
      checks        = 0;
      frames_done   = 0;
      pre_cnt       = 0;
      ack_wait      = 0;
      beats_left    = 0;
      burst_addr    = '0;
      prev_req      = 1'b0;
      prog_pending  = 1'b0;
      ready_pending = 1'b0;
      addr_s        = '0;
      wen_s         = 1'b0;
      wdata_s       = '0;
      arready_n     = 1'b0;
      rvalid_n      = 1'b0;
      rlast_n       = 1'b0;
      rdata_n       = '0;
      ack_n         = 1'b0;
      bd_mem        = '{default: '0};
      $readmemh("dv/eth_tx_stim.txt", stim);
      if (stim[0] === 'x) begin
         errors++;
         $display("The stimulus file dv/eth_tx_stim.txt could not be read");
      end
      frame_k = 0;
      load_frame(0, 0);
      program_desc();
      repeat (2) @(posedge clk_i);
      #2;
      arst_i = 1'b0;
      // No reads may start while transmit is disabled
      repeat (TXEN_OFF_CYCLES) @(posedge clk_i);
      #2;
      tx_en_i = 1'b1;
      wait (frames_done == NUM_FRAMES);
      repeat (10) @(posedge clk_i);
      check("prefill writes", 32'(8), 32'(pre_cnt));
      $display("Checks: %0d, errors: %0d", checks, errors);
      if (errors == 0) begin
         $display("*** PASSED ***");
      end else begin
         $display("*** FAILED ***");
      end
      $finish;
   end

   initial begin
      repeat (WATCHDOG_CYCLES) @(posedge clk_i);
      $display("Timeout after %0d cycles with %0d of %0d frames done",
               WATCHDOG_CYCLES, frames_done, NUM_FRAMES);
      $display("*** FAILED ***");
      $finish;
   end

endmodule

`default_nettype wire

// ==== dv/eth_tx_stim.txt ====
// Columns: descriptor control word, buffer pointer, index of the next descriptor
// One line per frame in service order, the first frame is served by descriptor 0
// Control word: length in 31:16, ready 15, irq 14, wrap 13, crc 11
// Descriptor 0, 20 bytes, irq and crc
0014C800 00001000 00000001
// Descriptor 1, 37 bytes from an unaligned pointer, wrap set
0025A000 00002003 00000000
// Descriptor 0 again, ready clear until the testbench sets it
00050800 00003001 00000001
// Descriptor 1, exactly one full burst
0010C800 00004000 00000002
// Descriptor 2, last in a ring of three
0021C000 00005002 00000000
// Descriptor 0, single byte
00018000 000060FF 00000001

// ==== verilog.f ====
common/eth_dma_pkg.sv
logic/frame_writer.sv
tx_dma/bd_fetch.sv
tx_dma/burst_reader.sv
tx_dma/eth_tx_dma.sv
dv/tb_eth_tx_dma.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the transmit DMA testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --assert --timing -j 0 \
   --top-module tb_eth_tx_dma \
   -f verilog.f \
   -o tb_eth_tx_dma

./obj_dir/tb_eth_tx_dma > sim.log 2>&1 || true
cat sim.log

if grep -q "\*\*\* FAILED \*\*\*" sim.log; then
   exit 1
fi
grep -q "\*\*\* PASSED \*\*\*" sim.log
